//--- sources.f
+incdir+source
source/rv32i_isa_pkg.sv
source/cpu_ctrl_pkg.sv
source/stage_if.sv
source/decode.sv
source/execute.sv
source/result.sv
source/cpu.sv
verif/clk_gen.sv
verif/cpu_assert.sv
verif/tb_cpu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cpu testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_cpu -o sim_cpu

./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "sim passed" sim.log; then
    exit 0
else
    exit 1
fi

//--- verif/tb_cpu.sv
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module tb_cpu;
    localparam int NUM_TESTS = 5;
    localparam int DONE_ADDR = 32'hFC;  // Final store of every program

    logic                      clk;
    logic                      rst_n;
    rv32i_isa_pkg::rv32i_word  i_addr;
    rv32i_isa_pkg::rv32i_word  i_rdata;
    logic                      i_read;
    logic                      i_resp;
    rv32i_isa_pkg::rv32i_word  d_addr;
    rv32i_isa_pkg::rv32i_word  d_rdata;
    rv32i_isa_pkg::rv32i_word  d_wdata;
    rv32i_isa_pkg::byte_mask_t d_byte_enable;
    logic                      d_read;
    logic                      d_write;
    logic                      d_resp;

    rv32i_isa_pkg::rv32i_word  rom [64];
    rv32i_isa_pkg::rv32i_word  ram [64];
    rv32i_isa_pkg::byte_mask_t mask_log [$];
    rv32i_isa_pkg::byte_mask_t exp_mask [$];
    rv32i_isa_pkg::rv32i_word  exp_addr [$];
    rv32i_isa_pkg::rv32i_word  exp_val [$];
    logic                      done;
    int                        n;
    int                        errors;

    clk_gen clk_gen_i (.clk(clk));

    cpu dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_addr        (i_addr),
        .i_rdata       (i_rdata),
        .i_read        (i_read),
        .i_resp        (i_resp),
        .d_addr        (d_addr),
        .d_rdata       (d_rdata),
        .d_wdata       (d_wdata),
        .d_byte_enable (d_byte_enable),
        .d_read        (d_read),
        .d_write       (d_write),
        .d_resp        (d_resp)
    );

    // Both memories answer one cycle after the request
    always @(posedge clk) begin
        i_resp <= i_read && !i_resp;
        i_rdata <= rom[i_addr[7:2]];
        d_resp <= (d_read || d_write) && !d_resp;
        d_rdata <= ram[d_addr[7:2]];
        if (d_write && !d_resp) begin
            for (int b = 0; b < 4; b++) begin
                if (d_byte_enable[b]) ram[d_addr[7:2]][8*b +: 8] = d_wdata[8*b +: 8];
            end
            mask_log.push_back(d_byte_enable);
            if (d_addr == DONE_ADDR) done <= 1'b1;
        end
    end

    function automatic rv32i_isa_pkg::rv32i_word enc_i(logic [11:0] imm, int rs1, logic [2:0] f3,
                                                      int rd, logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic rv32i_isa_pkg::rv32i_word enc_r(logic [6:0] f7, int rs2, int rs1,
                                                      logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv32i_isa_pkg::op_reg};
    endfunction

    function automatic rv32i_isa_pkg::rv32i_word enc_s(logic [11:0] imm, int rs2, int rs1,
                                                      logic [2:0] f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], rv32i_isa_pkg::op_store};
    endfunction

    function automatic rv32i_isa_pkg::rv32i_word enc_b(logic [12:0] imm, int rs1, int rs2,
                                                      logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11],
                rv32i_isa_pkg::op_br};
    endfunction

    function automatic rv32i_isa_pkg::rv32i_word enc_j(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), rv32i_isa_pkg::op_jal};
    endfunction

    task automatic put(input rv32i_isa_pkg::rv32i_word w);
        rom[n] = w;
        n++;
    endtask

    // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
    task automatic load_const(input int rd, input rv32i_isa_pkg::rv32i_word v);
        rv32i_isa_pkg::rv32i_word up;
        up = v + 32'h800;
        put({up[31:12], 5'(rd), rv32i_isa_pkg::op_lui});
        put(enc_i(v[11:0], rd, 3'b000, rd, rv32i_isa_pkg::op_imm));
    endtask

    task automatic store_expect(input int rs, input int addr, input rv32i_isa_pkg::rv32i_word v);
        put(enc_s(12'(addr), rs, 0, 3'b010));
        exp_addr.push_back(addr);
        exp_val.push_back(v);
    endtask

    task automatic check_word(input string what, input rv32i_isa_pkg::rv32i_word got,
                              input rv32i_isa_pkg::rv32i_word exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_mask(input string what, input rv32i_isa_pkg::byte_mask_t got,
                              input rv32i_isa_pkg::byte_mask_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic begin_prog();
        @(posedge clk);
        rst_n <= 1'b0;
        n = 0;
        done <= 1'b0;
        exp_addr.delete();
        exp_val.delete();
        exp_mask.delete();
        mask_log.delete();
        for (int i = 0; i < 64; i++) begin
            rom[i] = enc_j(21'h0, 0);
            ram[i] = $urandom;
        end
    endtask

    // Closes the program, releases reset and waits for the done store
    task automatic run_prog(input string name);
        int errs_before;
        errs_before = errors;
        put(enc_s(12'(DONE_ADDR), 0, 0, 3'b010));
        put(enc_j(21'h0, 0));  // Self-jump
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        while (!done) @(posedge clk);
        @(posedge clk);
        foreach (exp_addr[k]) check_word($sformatf("%s word %h", name, exp_addr[k]),
                                         ram[exp_addr[k][7:2]], exp_val[k]);
        foreach (exp_mask[k]) check_mask($sformatf("%s mask %0d", name, k),
                                         mask_log[k], exp_mask[k]);
        $display("test %s: %s", name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic test_alu();
        rv32i_isa_pkg::rv32i_word a;
        rv32i_isa_pkg::rv32i_word b;
        rv32i_isa_pkg::rv32i_word ci;
        logic [11:0]              c;
        begin_prog();
        a = $urandom;
        b = $urandom;
        c = 12'($urandom);
        ci = {{20{c[11]}}, c};
        load_const(1, a);
        load_const(2, b);
        put(enc_r(7'h00, 2, 1, 3'b000, 3));
        store_expect(3, 32'h80, a + b);
        put(enc_r(7'h20, 2, 1, 3'b000, 3));
        store_expect(3, 32'h84, a - b);
        put(enc_r(7'h00, 2, 1, 3'b100, 3));
        store_expect(3, 32'h88, a ^ b);
        put(enc_r(7'h00, 2, 1, 3'b110, 3));
        store_expect(3, 32'h8C, a | b);
        put(enc_r(7'h00, 2, 1, 3'b111, 3));
        store_expect(3, 32'h90, a & b);
        put(enc_r(7'h00, 2, 1, 3'b010, 3));
        store_expect(3, 32'h94, {31'b0, $signed(a) < $signed(b)});
        put(enc_r(7'h00, 2, 1, 3'b001, 3));
        store_expect(3, 32'h98, a << b[4:0]);
        put(enc_r(7'h00, 2, 1, 3'b101, 3));
        store_expect(3, 32'h9C, a >> b[4:0]);
        put(enc_i(c, 1, 3'b000, 4, rv32i_isa_pkg::op_imm));
        store_expect(4, 32'hA0, a + ci);
        put(enc_i(c, 1, 3'b100, 4, rv32i_isa_pkg::op_imm));
        store_expect(4, 32'hA4, a ^ ci);
        put(enc_i(c, 1, 3'b110, 4, rv32i_isa_pkg::op_imm));
        store_expect(4, 32'hA8, a | ci);
        put(enc_i(c, 1, 3'b111, 4, rv32i_isa_pkg::op_imm));
        store_expect(4, 32'hAC, a & ci);
        put(enc_i(c, 1, 3'b010, 4, rv32i_isa_pkg::op_imm));
        store_expect(4, 32'hB0, {31'b0, $signed(a) < $signed(ci)});
        put(enc_i({7'b0, c[4:0]}, 1, 3'b001, 4, rv32i_isa_pkg::op_imm));
        store_expect(4, 32'hB4, a << c[4:0]);
        put(enc_i({7'b0, c[4:0]}, 1, 3'b101, 4, rv32i_isa_pkg::op_imm));
        store_expect(4, 32'hB8, a >> c[4:0]);
        run_prog("alu");
    endtask

    task automatic test_lui_slt();
        begin_prog();
        put({20'hABCDE, 5'd3, rv32i_isa_pkg::op_lui});
        store_expect(3, 32'h80, 32'hABCDE000);
        put(enc_i(12'd4, 3, 3'b001, 4, rv32i_isa_pkg::op_imm));
        store_expect(4, 32'h84, 32'hBCDE0000);
        put(enc_i(12'd8, 3, 3'b101, 5, rv32i_isa_pkg::op_imm));
        store_expect(5, 32'h88, 32'h00ABCDE0);
        put(enc_r(7'h00, 0, 3, 3'b010, 6));  // Negative below zero
        store_expect(6, 32'h8C, 32'd1);
        put(enc_r(7'h00, 3, 0, 3'b010, 7));
        store_expect(7, 32'h90, 32'd0);
        put({20'h12345, 5'd0, rv32i_isa_pkg::op_lui});
        put(enc_i(12'd5, 0, 3'b000, 0, rv32i_isa_pkg::op_imm));
        store_expect(0, 32'h94, 32'd0);
        run_prog("lui_slt");
    endtask

    task automatic test_branch();
        logic [2:0] f3 [4];
        int         addr;
        int         jal_pc;
        f3 = '{3'b000, 3'b001, 3'b100, 3'b101};  // beq bne blt bge
        begin_prog();
        put(enc_i(-12'sd5, 0, 3'b000, 1, rv32i_isa_pkg::op_imm));
        put(enc_i(12'd3, 0, 3'b000, 2, rv32i_isa_pkg::op_imm));
        addr = 32'h80;
        for (int k = 0; k < 4; k++) begin
            for (int same = 0; same < 2; same++) begin
                logic taken;
                case (k)
                    0: taken = (same == 1);
                    1: taken = (same == 0);
                    2: taken = (same == 0);  // -5 < 3
                    default: taken = (same == 1);
                endcase
                put(enc_i(12'd2, 0, 3'b000, 9, rv32i_isa_pkg::op_imm));
                put(enc_b(13'd8, 1, same ? 1 : 2, f3[k]));
                put(enc_i(12'd1, 0, 3'b000, 9, rv32i_isa_pkg::op_imm));
                store_expect(9, addr, taken ? 32'd2 : 32'd1);
                addr += 4;
            end
        end
        jal_pc = `RESET_PC + 4 * n;
        put(enc_j(21'd8, 10));
        put(enc_i(12'd7, 0, 3'b000, 11, rv32i_isa_pkg::op_imm));  // Skipped by JAL
        store_expect(10, addr, jal_pc + 4);
        store_expect(11, addr + 4, 32'd0);
        run_prog("branch");
    endtask

    task automatic test_load();
        rv32i_isa_pkg::rv32i_word w;
        logic [7:0]               by;
        begin_prog();
        w = ram[40];
        put(enc_i(12'hA0, 0, 3'b010, 3, rv32i_isa_pkg::op_load));
        store_expect(3, 32'h80, w);
        for (int off = 0; off < 4; off++) begin
            by = w[8*off +: 8];
            put(enc_i(12'(32'hA0 + off), 0, 3'b000, 4, rv32i_isa_pkg::op_load));
            store_expect(4, 32'h84 + 8 * off, {{24{by[7]}}, by});
            put(enc_i(12'(32'hA0 + off), 0, 3'b100, 5, rv32i_isa_pkg::op_load));
            store_expect(5, 32'h88 + 8 * off, {24'h0, by});
        end
        run_prog("load");
    endtask

    task automatic test_sb();
        rv32i_isa_pkg::rv32i_word  w;
        logic [7:0]                by;
        rv32i_isa_pkg::byte_mask_t m;
        begin_prog();
        by = 8'($urandom);
        put(enc_i({4'h0, by}, 0, 3'b000, 1, rv32i_isa_pkg::op_imm));
        for (int off = 0; off < 4; off++) begin
            w = ram[48 + off];
            w[8*off +: 8] = by;  // Only this lane may change
            put(enc_s(12'(32'hC0 + 5 * off), 1, 0, 3'b000));
            exp_addr.push_back(32'hC0 + 4 * off);
            exp_val.push_back(w);
            m = '0;
            m[off] = 1'b1;  // Lane picked by the low address bits
            exp_mask.push_back(m);
        end
        run_prog("sb");
    endtask

    initial begin
        #(NUM_TESTS * 400 * 100);
        $display("Watchdog timeout: the DUT did not finish the tests in time");
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h76fd));
        rst_n = 1'b0;
        i_resp = 1'b0;
        i_rdata = '0;
        d_resp = 1'b0;
        d_rdata = '0;
        errors = 0;
        test_alu();
        test_lui_slt();
        test_branch();
        test_load();
        test_sb();
        $display("tests %0d, errors %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end
endmodule

//--- verif/cpu_assert.sv
`timescale 1ns/1ps

module cpu_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     i_read,
    input logic                     i_resp,
    input logic                     d_read,
    input logic                     d_write,
    input logic                     d_resp,
    input rv32i_isa_pkg::rv32i_word d_addr
);
    data_excl: assert property (@(posedge clk) disable iff (!rst_n) !(d_read && d_write))
        else $error("d_read and d_write high together");

    port_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_read && (d_read || d_write)))
        else $error("instruction and data request high together");

    i_hold: assert property (@(posedge clk) disable iff (!rst_n) i_read && !i_resp |=> i_read)
        else $error("i_read dropped before i_resp");

    d_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (d_read || d_write) && !d_resp |=> (d_read || d_write))
        else $error("data request dropped before d_resp");

    // Address held while the data memory has not answered
    d_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (d_read || d_write) && !d_resp |=> $stable(d_addr))
        else $error("d_addr changed before d_resp");
endmodule

bind cpu cpu_assert assert_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_read  (i_read),
    .i_resp  (i_resp),
    .d_read  (d_read),
    .d_write (d_write),
    .d_resp  (d_resp),
    .d_addr  (d_addr)
);

//--- verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end
endmodule

//--- source/cpu.sv
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module cpu (
    input  logic                      clk,
    input  logic                      rst_n,

    // Instruction memory
    output rv32i_isa_pkg::rv32i_word  i_addr,
    input  rv32i_isa_pkg::rv32i_word  i_rdata,
    output logic                      i_read,
    input  logic                      i_resp,

    // Data memory, word aligned
    output rv32i_isa_pkg::rv32i_word  d_addr,
    input  rv32i_isa_pkg::rv32i_word  d_rdata,
    output rv32i_isa_pkg::rv32i_word  d_wdata,
    output rv32i_isa_pkg::byte_mask_t d_byte_enable,
    output logic                      d_read,
    output logic                      d_write,
    input  logic                      d_resp
);
    cpu_ctrl_pkg::cpu_state_t  state;
    rv32i_isa_pkg::rv32i_word  pc;
    rv32i_isa_pkg::rv32i_word  ir;
    rv32i_isa_pkg::rv32i_word  load_data;
    rv32i_isa_pkg::rv32i_word  alu_out;
    rv32i_isa_pkg::rv32i_word  rd_wdata;
    rv32i_isa_pkg::rv32i_word  next_pc;
    logic                      br_en;
    logic                      rd_we;
    logic                      wb_we;

    stage_if stage ();

    decode decode_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (ir),
        .pc       (pc),
        .rd_we    (wb_we),
        .rd_wdata (rd_wdata),
        .stage    (stage)
    );

    execute execute_i (
        .stage   (stage),
        .alu_out (alu_out),
        .br_en   (br_en)
    );

    result result_i (
        .stage           (stage),
        .alu_out         (alu_out),
        .br_en           (br_en),
        .load_data       (load_data),
        .mem_addr        (d_addr),
        .mem_wdata       (d_wdata),
        .mem_byte_enable (d_byte_enable),
        .rd_wdata        (rd_wdata),
        .rd_we           (rd_we),
        .next_pc         (next_pc)
    );

    assign i_addr = pc;
    assign wb_we  = rd_we && (state == cpu_ctrl_pkg::st_writeback);  // Single write per instruction

    // Requests are registered so they drop the cycle after resp
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= cpu_ctrl_pkg::st_fetch;
            pc      <= `RESET_PC;
            i_read  <= 1'b0;
            d_read  <= 1'b0;
            d_write <= 1'b0;
        end else begin
            case (state)
                cpu_ctrl_pkg::st_fetch: begin
                    if (i_read && i_resp) begin
                        i_read <= 1'b0;
                        state  <= cpu_ctrl_pkg::st_decode;
                    end else begin
                        i_read <= 1'b1;
                    end
                end
                cpu_ctrl_pkg::st_decode: state <= cpu_ctrl_pkg::st_execute;
                cpu_ctrl_pkg::st_execute: begin
                    if (stage.ctrl.mem_read || stage.ctrl.mem_write) begin
                        d_read  <= stage.ctrl.mem_read;
                        d_write <= stage.ctrl.mem_write;
                        state   <= cpu_ctrl_pkg::st_memory;
                    end else begin
                        state   <= cpu_ctrl_pkg::st_writeback;
                    end
                end
                cpu_ctrl_pkg::st_memory: begin
                    if (d_resp) begin  // Hold request until memory answers
                        d_read  <= 1'b0;
                        d_write <= 1'b0;
                        state   <= cpu_ctrl_pkg::st_writeback;
                    end
                end
                default: begin
                    pc     <= next_pc;
                    i_read <= 1'b1;  // Next fetch starts with the new PC
                    state  <= cpu_ctrl_pkg::st_fetch;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_ctrl_pkg::st_fetch && i_read && i_resp) begin
            ir <= i_rdata;
        end
        if (state == cpu_ctrl_pkg::st_memory && d_read && d_resp) begin
            load_data <= d_rdata;
        end
    end
endmodule

//--- source/result.sv
`timescale 1ns/1ps

module result (
    stage_if.res                      stage,
    input  rv32i_isa_pkg::rv32i_word  alu_out,
    input  logic                      br_en,
    input  rv32i_isa_pkg::rv32i_word  load_data,
    output rv32i_isa_pkg::rv32i_word  mem_addr,
    output rv32i_isa_pkg::rv32i_word  mem_wdata,
    output rv32i_isa_pkg::byte_mask_t mem_byte_enable,
    output rv32i_isa_pkg::rv32i_word  rd_wdata,
    output logic                      rd_we,
    output rv32i_isa_pkg::rv32i_word  next_pc
);
    logic [1:0]               offset;
    logic [7:0]               load_byte;
    rv32i_isa_pkg::rv32i_word load_value;
    rv32i_isa_pkg::rv32i_word pc_plus4;
    logic                     take_target;

    assign offset    = alu_out[1:0];
    assign mem_addr  = {alu_out[31:2], 2'b00};  // Memory only sees word addresses
    assign load_byte = load_data[{offset, 3'b000} +: 8];

    // Byte stores replicate the data and enable a single lane
    always_comb begin
        if (stage.ctrl.funct3 == rv32i_isa_pkg::lw) begin
            mem_wdata       = stage.rs2_data;
            mem_byte_enable = 4'b1111;
        end else begin
            mem_wdata       = {4{stage.rs2_data[7:0]}};
            mem_byte_enable = 4'b0001 << offset;
        end
    end

    always_comb begin
        case (stage.ctrl.funct3)
            rv32i_isa_pkg::lb:  load_value = {{24{load_byte[7]}}, load_byte};
            rv32i_isa_pkg::lbu: load_value = {24'h000000, load_byte};
            default:            load_value = load_data;
        endcase
    end

    assign pc_plus4 = stage.pc + 32'd4;

    always_comb begin
        case (stage.ctrl.wb_sel)
            cpu_ctrl_pkg::wb_load:     rd_wdata = load_value;
            cpu_ctrl_pkg::wb_pc_plus4: rd_wdata = pc_plus4;
            cpu_ctrl_pkg::wb_imm:      rd_wdata = stage.imm;  // LUI
            default:                   rd_wdata = alu_out;
        endcase
    end

    assign rd_we = stage.ctrl.reg_write && (stage.rd != '0);

    assign take_target = stage.ctrl.is_jump || (stage.ctrl.is_branch && br_en);
    assign next_pc     = take_target ? (stage.pc + stage.imm) : pc_plus4;
endmodule

//--- source/execute.sv
`timescale 1ns/1ps

module execute (
    stage_if.exe                     stage,
    output rv32i_isa_pkg::rv32i_word alu_out,
    output logic                     br_en
);
    rv32i_isa_pkg::rv32i_word opa;
    rv32i_isa_pkg::rv32i_word opb;
    logic [4:0]               shamt;

    assign opa   = stage.rs1_data;
    assign opb   = stage.ctrl.use_imm ? stage.imm : stage.rs2_data;
    assign shamt = opb[4:0];

    // Loads and stores arrive here as add with imm, giving the address
    always_comb begin
        case (stage.ctrl.aluop)
            rv32i_isa_pkg::alu_add: alu_out = opa + opb;
            rv32i_isa_pkg::alu_sub: alu_out = opa - opb;
            rv32i_isa_pkg::alu_sll: alu_out = opa << shamt;
            rv32i_isa_pkg::alu_srl: alu_out = opa >> shamt;
            rv32i_isa_pkg::alu_xor: alu_out = opa ^ opb;
            rv32i_isa_pkg::alu_or:  alu_out = opa | opb;
            rv32i_isa_pkg::alu_and: alu_out = opa & opb;
            rv32i_isa_pkg::alu_slt: begin
                alu_out = rv32i_isa_pkg::rv32i_word'($signed(opa) < $signed(opb));
            end
            default: alu_out = opa + opb;
        endcase
    end

    // Branch compare always on the two registers
    always_comb begin
        case (stage.ctrl.cmpop)
            rv32i_isa_pkg::beq: br_en = (stage.rs1_data == stage.rs2_data);
            rv32i_isa_pkg::bne: br_en = (stage.rs1_data != stage.rs2_data);
            rv32i_isa_pkg::blt: br_en = ($signed(stage.rs1_data) < $signed(stage.rs2_data));
            rv32i_isa_pkg::bge: br_en = ($signed(stage.rs1_data) >= $signed(stage.rs2_data));
            default:            br_en = 1'b0;
        endcase
    end
endmodule

//--- source/decode.sv
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rv32i_isa_pkg::rv32i_word instr,
    input  rv32i_isa_pkg::rv32i_word pc,
    input  logic                     rd_we,
    input  rv32i_isa_pkg::rv32i_word rd_wdata,
    stage_if.dec                     stage
);
    rv32i_isa_pkg::rv32i_word regs [`NUM_REGS];
    rv32i_isa_pkg::opcode_t   opcode;
    rv32i_isa_pkg::rv32i_reg  rs1;
    rv32i_isa_pkg::rv32i_reg  rs2;
    rv32i_isa_pkg::rv32i_reg  rd;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    rv32i_isa_pkg::rv32i_word imm_i;
    rv32i_isa_pkg::rv32i_word imm_s;
    rv32i_isa_pkg::rv32i_word imm_b;
    rv32i_isa_pkg::rv32i_word imm_u;
    rv32i_isa_pkg::rv32i_word imm_j;

    assign opcode = rv32i_isa_pkg::opcode_t'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // Immediate formats, all sign extended from bit 31 except U
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        stage.ctrl        = '0;
        stage.ctrl.aluop  = rv32i_isa_pkg::alu_add;  // Address adder by default
        stage.ctrl.cmpop  = rv32i_isa_pkg::branch_funct3_t'(funct3);
        stage.ctrl.funct3 = funct3;
        stage.ctrl.wb_sel = cpu_ctrl_pkg::wb_alu;
        stage.imm         = imm_i;
        case (opcode)
            rv32i_isa_pkg::op_lui: begin
                stage.imm             = imm_u;
                stage.ctrl.wb_sel     = cpu_ctrl_pkg::wb_imm;
                stage.ctrl.reg_write  = 1'b1;
            end
            rv32i_isa_pkg::op_jal: begin
                stage.imm             = imm_j;
                stage.ctrl.is_jump    = 1'b1;
                stage.ctrl.wb_sel     = cpu_ctrl_pkg::wb_pc_plus4;  // Link value
                stage.ctrl.reg_write  = 1'b1;
            end
            rv32i_isa_pkg::op_br: begin
                stage.imm             = imm_b;
                stage.ctrl.is_branch  = 1'b1;
            end
            rv32i_isa_pkg::op_load: begin
                stage.ctrl.use_imm    = 1'b1;
                stage.ctrl.mem_read   = 1'b1;
                stage.ctrl.wb_sel     = cpu_ctrl_pkg::wb_load;
                stage.ctrl.reg_write  = 1'b1;
            end
            rv32i_isa_pkg::op_store: begin
                stage.imm             = imm_s;
                stage.ctrl.use_imm    = 1'b1;
                stage.ctrl.mem_write  = 1'b1;
            end
            rv32i_isa_pkg::op_imm: begin
                stage.ctrl.aluop      = rv32i_isa_pkg::alu_ops'({1'b0, funct3});
                stage.ctrl.use_imm    = 1'b1;
                stage.ctrl.reg_write  = 1'b1;
            end
            rv32i_isa_pkg::op_reg: begin
                // funct7[5] only selects SUB here
                stage.ctrl.aluop      = rv32i_isa_pkg::alu_ops'({funct7[5], funct3});
                stage.ctrl.reg_write  = 1'b1;
            end
            default: begin
                stage.ctrl.aluop      = rv32i_isa_pkg::alu_add;  // Unknown opcode acts as a nop
            end
        endcase
    end

    assign stage.pc       = pc;
    assign stage.rd       = rd;
    assign stage.rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign stage.rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != '0) begin
            regs[rd] <= rd_wdata;
        end
    end
endmodule

//--- source/stage_if.sv
`timescale 1ns/1ps

// One decoded instruction with its operands
interface stage_if;
    cpu_ctrl_pkg::ctrl_word_t  ctrl;
    rv32i_isa_pkg::rv32i_word  pc;
    rv32i_isa_pkg::rv32i_word  rs1_data;
    rv32i_isa_pkg::rv32i_word  rs2_data;
    rv32i_isa_pkg::rv32i_word  imm;
    rv32i_isa_pkg::rv32i_reg   rd;

    modport dec (
        output ctrl, pc, rs1_data, rs2_data, imm, rd
    );

    modport exe (
        input ctrl, rs1_data, rs2_data, imm
    );

    modport res (
        input ctrl, pc, rs2_data, imm, rd
    );
endinterface

//--- source/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } cpu_state_t;

    // Source of the register file write value
    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc_plus4,
        wb_imm
    } wb_sel_t;

    typedef struct packed {
        rv32i_isa_pkg::alu_ops         aluop;
        rv32i_isa_pkg::branch_funct3_t cmpop;
        logic                          use_imm;    // ALU operand B is imm
        logic                          is_branch;
        logic                          is_jump;
        logic                          mem_read;
        logic                          mem_write;
        logic [2:0]                    funct3;     // Access size for loads and stores
        wb_sel_t                       wb_sel;
        logic                          reg_write;
    } ctrl_word_t;

endpackage

//--- source/rv32i_isa_pkg.sv
`include "rv32i_macros.svh"

package rv32i_isa_pkg;

    typedef logic [`XLEN-1:0] rv32i_word;
    typedef logic [4:0] rv32i_reg;
    typedef logic [3:0] byte_mask_t;  // One bit per byte lane

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_jal   = 7'b1101111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // Low three bits follow funct3, bit 3 is funct7[5]
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_slt = 4'b0010,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000
    } alu_ops;

    typedef enum logic [2:0] {
        beq = 3'b000,
        bne = 3'b001,
        blt = 3'b100,
        bge = 3'b101
    } branch_funct3_t;

    // SB shares 000 with LB and SW shares 010 with LW
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lw  = 3'b010,
        lbu = 3'b100
    } load_funct3_t;

endpackage

//--- source/rv32i_macros.svh
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// Datapath word width
`define XLEN 32

// Architectural register count
`define NUM_REGS 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
